// ==== hw/fixp_pkg.sv ====
package fixp_pkg;

    // Element width and binary point position
    localparam int WIDTH      = 16;
    localparam int FRAC_WIDTH = 8;

    // Weights, activations and results share one format
    typedef logic signed [WIDTH-1:0] elem_t;

    // Room for a sum of two full products
    typedef logic signed [2*WIDTH:0] acc_t;

endpackage

// ==== hw/wbuf_pkg.sv ====
package wbuf_pkg;

    // Matrix held in one buffer
    localparam int ROW = 8;
    localparam int COL = 8;

    // Block shape
    localparam int BLOCK_SIZE    = 2;
    localparam int CHUNK_SIZE    = 4;
    localparam int COLS_PER_CORE = CHUNK_SIZE / BLOCK_SIZE;

    // Scan extents
    localparam int TOTAL_BLOCKS = ROW / BLOCK_SIZE;
    localparam int COL_GROUPS   = COL / BLOCK_SIZE;

    typedef logic [COL*fixp_pkg::WIDTH-1:0]        row_t;
    typedef logic [CHUNK_SIZE*fixp_pkg::WIDTH-1:0] blk_t;

    typedef logic [$clog2(ROW)-1:0] row_addr_t;
    typedef logic [$clog2(COL)-1:0] col_idx_t;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        PROCESS,
        DONE
    } conv_state_t;

endpackage

// ==== hw/row_assembler.sv ====
`timescale 1ns/10ps

module row_assembler (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_elem_valid,
    input  fixp_pkg::elem_t   in_elem,
    output logic              row_valid,
    output wbuf_pkg::row_t    row_data
);

    import fixp_pkg::*;
    import wbuf_pkg::*;

    col_idx_t elem_idx;
    row_t     shift_row;
    row_t     next_row;
    logic     row_complete;

    // Newest element enters at the top, element 0 ends up at the bottom
    assign next_row     = {in_elem, shift_row[COL*WIDTH-1:WIDTH]};
    assign row_complete = in_elem_valid && (elem_idx == col_idx_t'(COL - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_idx <= '0;
        end else if (in_elem_valid) begin
            if (row_complete) begin
                elem_idx <= '0;
            end else begin
                elem_idx <= elem_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_elem_valid) begin
            shift_row <= next_row;
        end
    end

    // One cycle pulse per finished row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= row_complete;
        end
    end

    always_ff @(posedge clk) begin
        if (row_complete) begin
            row_data <= next_row;
        end
    end

endmodule

// ==== hw/ram_1w2r.sv ====
`timescale 1ns/10ps

module ram_1w2r #(
    parameter int DATA_WIDTH = 128,
    parameter int DEPTH      = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  logic [$clog2(DEPTH)-1:0] read_addr0,
    input  logic [$clog2(DEPTH)-1:0] read_addr1,
    input  logic [DATA_WIDTH-1:0]    din,
    output logic [DATA_WIDTH-1:0]    dout0,
    output logic [DATA_WIDTH-1:0]    dout1
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= din;
        end
    end

    // Write-first on both read ports
    always_ff @(posedge clk) begin
        dout0 <= (we && (write_addr == read_addr0)) ? din : mem[read_addr0];
        dout1 <= (we && (write_addr == read_addr1)) ? din : mem[read_addr1];
    end

endmodule

// ==== hw/r2b_converter_w.sv ====
`timescale 1ns/10ps

module r2b_converter_w (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic            row_valid,
    input  wbuf_pkg::row_t  row_data,
    output logic            blk_valid,
    output wbuf_pkg::blk_t  blk_data,
    output logic            slice_done,
    output logic            slice_last,
    output logic            buffer_done
);

    import fixp_pkg::*;
    import wbuf_pkg::*;

    conv_state_t state;
    conv_state_t state_next;

    row_addr_t row_cnt;
    logic      ram_we;
    row_addr_t read_addr0;
    row_addr_t read_addr1;
    row_t      dout0;
    row_t      dout1;

    logic [$clog2(TOTAL_BLOCKS)-1:0] br;
    logic [$clog2(COL_GROUPS)-1:0]   cg;
    logic                            scan_end;

    // First pipeline stage aligned with the RAM read data
    logic                            vld_d1;
    logic                            last_br_d1;
    logic [$clog2(COL_GROUPS)-1:0]   cg_d1;

    row_t rd_row [BLOCK_SIZE];
    blk_t blk_next;

    assign scan_end = (br == TOTAL_BLOCKS - 1) && (cg == COL_GROUPS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (en) begin
                    state_next = FILL;
                end
            end
            FILL: begin
                if (row_valid && (row_cnt == row_addr_t'(ROW - 1))) begin
                    state_next = PROCESS;
                end
            end
            PROCESS: begin
                if (scan_end) begin
                    state_next = DONE;
                end
            end
            DONE: state_next = IDLE;
        endcase
    end

    // Rows outside FILL are dropped
    assign ram_we = (state == FILL) && row_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (ram_we) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // Block row is the inner loop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            br <= '0;
            cg <= '0;
        end else if (state == PROCESS) begin
            if (br == TOTAL_BLOCKS - 1) begin
                br <= '0;
                cg <= cg + 1'b1;
            end else begin
                br <= br + 1'b1;
            end
        end
    end

    // Rows 2*br and 2*br+1
    assign read_addr0 = {br, 1'b0};
    assign read_addr1 = {br, 1'b1};

    ram_1w2r #(
        .DATA_WIDTH ($bits(row_t)),
        .DEPTH      (ROW)
    ) u_ram (
        .clk        (clk),
        .we         (ram_we),
        .write_addr (row_cnt),
        .read_addr0 (read_addr0),
        .read_addr1 (read_addr1),
        .din        (row_data),
        .dout0      (dout0),
        .dout1      (dout1)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_d1 <= 1'b0;
        end else begin
            vld_d1 <= (state == PROCESS);
        end
    end

    always_ff @(posedge clk) begin
        cg_d1      <= cg;
        last_br_d1 <= (br == TOTAL_BLOCKS - 1);
    end

    assign rd_row[0] = dout0;
    assign rd_row[1] = dout1;

    // Element k comes from row k mod 2, column 2*cg + k/2
    always_comb begin
        col_idx_t col_sel;
        for (int k = 0; k < CHUNK_SIZE; k++) begin
            col_sel = col_idx_t'(cg_d1 * COLS_PER_CORE + k / BLOCK_SIZE);
            blk_next[k*WIDTH +: WIDTH] = rd_row[k % BLOCK_SIZE][col_sel*WIDTH +: WIDTH];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_valid  <= 1'b0;
            slice_done <= 1'b0;
            slice_last <= 1'b0;
        end else begin
            blk_valid  <= vld_d1;
            slice_done <= vld_d1 && last_br_d1;
            slice_last <= vld_d1 && last_br_d1 && (cg_d1 == COL_GROUPS - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (vld_d1) begin
            blk_data <= blk_next;
        end
    end

    // Comes out while the last block is still in the pipeline
    assign buffer_done = (state == DONE);

endmodule

// ==== hw/weight_block_core.sv ====
`timescale 1ns/10ps

module weight_block_core (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             blk_valid,
    input  wbuf_pkg::blk_t   blk_data,
    input  fixp_pkg::elem_t  act0,
    input  fixp_pkg::elem_t  act1,
    output logic             y_valid,
    output fixp_pkg::elem_t  y0,
    output fixp_pkg::elem_t  y1
);

    import fixp_pkg::*;
    import wbuf_pkg::*;

    elem_t w [CHUNK_SIZE];
    acc_t  sum0;
    acc_t  sum1;
    acc_t  scaled0;
    acc_t  scaled1;

    // Order is w00, w10, w01, w11
    always_comb begin
        for (int k = 0; k < CHUNK_SIZE; k++) begin
            w[k] = blk_data[k*WIDTH +: WIDTH];
        end
    end

    // Operands widen to the accumulator before the multiply
    assign sum0 = w[0] * act0 + w[2] * act1;
    assign sum1 = w[1] * act0 + w[3] * act1;

    assign scaled0 = sum0 >>> FRAC_WIDTH;
    assign scaled1 = sum1 >>> FRAC_WIDTH;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_valid <= 1'b0;
        end else begin
            y_valid <= blk_valid;
        end
    end

    // Keep low bits only, wraps on overflow
    always_ff @(posedge clk) begin
        if (blk_valid) begin
            y0 <= scaled0[WIDTH-1:0];
            y1 <= scaled1[WIDTH-1:0];
        end
    end

endmodule

// ==== hw/weight_stream_top.sv ====
`timescale 1ns/10ps

module weight_stream_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  logic             in_elem_valid,
    input  fixp_pkg::elem_t  in_elem,
    input  fixp_pkg::elem_t  act0,
    input  fixp_pkg::elem_t  act1,
    output logic             blk_valid,
    output wbuf_pkg::blk_t   blk_data,
    output logic             slice_done,
    output logic             slice_last,
    output logic             buffer_done,
    output logic             y_valid,
    output fixp_pkg::elem_t  y0,
    output fixp_pkg::elem_t  y1
);

    import wbuf_pkg::*;

    logic row_valid;
    row_t row_data;

    row_assembler u_row_assembler (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_elem_valid (in_elem_valid),
        .in_elem       (in_elem),
        .row_valid     (row_valid),
        .row_data      (row_data)
    );

    r2b_converter_w u_r2b_converter_w (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .row_valid   (row_valid),
        .row_data    (row_data),
        .blk_valid   (blk_valid),
        .blk_data    (blk_data),
        .slice_done  (slice_done),
        .slice_last  (slice_last),
        .buffer_done (buffer_done)
    );

    weight_block_core u_weight_block_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_valid (blk_valid),
        .blk_data  (blk_data),
        .act0      (act0),
        .act1      (act1),
        .y_valid   (y_valid),
        .y0        (y0),
        .y1        (y1)
    );

endmodule

// ==== bench/weight_stream_sva.sv ====
`timescale 1ns/10ps

module weight_stream_sva (
    input logic                  clk,
    input logic                  rst_n,
    input wbuf_pkg::conv_state_t state,
    input logic                  blk_valid,
    input logic                  slice_done,
    input logic                  slice_last,
    input logic                  buffer_done
);

    import wbuf_pkg::*;

    a_slice_last_with_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        slice_last |-> slice_done
    ) else $error("slice_last high without slice_done");

    // One pulse per buffer
    a_buffer_done_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        buffer_done |=> !buffer_done
    ) else $error("buffer_done held for more than one cycle");

    a_no_block_in_fill: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == FILL) |-> !blk_valid
    ) else $error("blk_valid high while the converter fills its buffer");

endmodule

bind r2b_converter_w weight_stream_sva u_weight_stream_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .blk_valid   (blk_valid),
    .slice_done  (slice_done),
    .slice_last  (slice_last),
    .buffer_done (buffer_done)
);

// ==== bench/tb_weight_stream.sv ====
`timescale 1ns/10ps

module tb_weight_stream;

    import fixp_pkg::*;
    import wbuf_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_BUFFERS     = 2;
    localparam int BLOCKS_PER_BUF  = TOTAL_BLOCKS * COL_GROUPS;
    localparam int MAX_GAPS        = 12;
    localparam int WATCHDOG_CYCLES = NUM_BUFFERS * (ROW * COL + 40) + 100;

    logic  clk;
    logic  rst_n;
    logic  en;
    logic  in_elem_valid;
    elem_t in_elem;
    elem_t act0;
    elem_t act1;
    logic  blk_valid;
    blk_t  blk_data;
    logic  slice_done;
    logic  slice_last;
    logic  buffer_done;
    logic  y_valid;
    elem_t y0;
    elem_t y1;

    integer             seed;
    elem_t              matrix [ROW][COL];
    blk_t               exp_blk [$];
    logic [2*WIDTH-1:0] exp_y [$];
    int                 blk_count = 0;
    int                 y_count = 0;
    int                 blk_in_buf = 0;
    int                 buf_done_in_buf = 0;
    logic               prev_blk_valid = 1'b0;

    weight_stream_top u_weight_stream_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .in_elem_valid (in_elem_valid),
        .in_elem       (in_elem),
        .act0          (act0),
        .act1          (act1),
        .blk_valid     (blk_valid),
        .blk_data      (blk_data),
        .slice_done    (slice_done),
        .slice_last    (slice_last),
        .buffer_done   (buffer_done),
        .y_valid       (y_valid),
        .y0            (y0),
        .y1            (y1)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "Check of %s failed", name);
        end
    endtask

    // Element k holds W[2*br + k%2][2*cg + k/2]
    function automatic blk_t ref_block(input elem_t m [ROW][COL], input int cg, input int br);
        blk_t blk;
        for (int k = 0; k < CHUNK_SIZE; k++) begin
            blk[k*WIDTH +: WIDTH] = m[2*br + k % 2][2*cg + k / 2];
        end
        return blk;
    endfunction

    // Returns {y1, y0}
    function automatic logic [2*WIDTH-1:0] ref_core(input blk_t blk, input elem_t a0,
                                                    input elem_t a1);
        longint w00;
        longint w10;
        longint w01;
        longint w11;
        longint s0;
        longint s1;
        w00 = longint'(elem_t'(blk[0*WIDTH +: WIDTH]));
        w10 = longint'(elem_t'(blk[1*WIDTH +: WIDTH]));
        w01 = longint'(elem_t'(blk[2*WIDTH +: WIDTH]));
        w11 = longint'(elem_t'(blk[3*WIDTH +: WIDTH]));
        s0 = (w00 * longint'(a0) + w01 * longint'(a1)) >>> FRAC_WIDTH;
        s1 = (w10 * longint'(a0) + w11 * longint'(a1)) >>> FRAC_WIDTH;
        return {s1[WIDTH-1:0], s0[WIDTH-1:0]};
    endfunction

    // New weights and activations, expectations queued in scan order
    task automatic prepare_buffer();
        blk_t blk;
        for (int r = 0; r < ROW; r++) begin
            for (int c = 0; c < COL; c++) begin
                matrix[r][c] = elem_t'($random(seed));
            end
        end
        act0 = {1'b1, 15'($random(seed))};
        act1 = {1'b0, 15'($random(seed))};
        for (int cg = 0; cg < COL_GROUPS; cg++) begin
            for (int br = 0; br < TOTAL_BLOCKS; br++) begin
                blk = ref_block(matrix, cg, br);
                exp_blk.push_back(blk);
                exp_y.push_back(ref_core(blk, act0, act1));
            end
        end
    endtask

    task automatic feed_buffer();
        int gaps;
        gaps = 0;
        for (int r = 0; r < ROW; r++) begin
            for (int c = 0; c < COL; c++) begin
                in_elem_valid = 1'b1;
                in_elem       = matrix[r][c];
                @(negedge clk);
                if (gaps < MAX_GAPS && ($random(seed) & 3) == 0) begin
                    in_elem_valid = 1'b0;
                    gaps++;
                    @(negedge clk);
                end
            end
        end
        in_elem_valid = 1'b0;
    endtask

    // Start pulse and one junk row while blocks stream out
    task automatic disturb_process();
        while (!blk_valid) begin
            @(negedge clk);
        end
        en = 1'b1;
        @(negedge clk);
        en = 1'b0;
        for (int c = 0; c < COL; c++) begin
            in_elem_valid = 1'b1;
            in_elem       = elem_t'($random(seed));
            @(negedge clk);
        end
        in_elem_valid = 1'b0;
    endtask

    initial begin
        seed          = 32'h8672e003;
        rst_n         = 1'b0;
        en            = 1'b0;
        in_elem_valid = 1'b0;
        in_elem       = '0;
        act0          = '0;
        act1          = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("blk_valid", blk_valid, 0);
            check_value("slice_done", slice_done, 0);
            check_value("slice_last", slice_last, 0);
            check_value("buffer_done", buffer_done, 0);
            check_value("y_valid", y_valid, 0);
        end
        for (int b = 0; b < NUM_BUFFERS; b++) begin
            prepare_buffer();
            en = 1'b1;
            @(negedge clk);
            en = 1'b0;
            feed_buffer();
            if (b == 0) begin
                disturb_process();
            end
            while (y_count < (b + 1) * BLOCKS_PER_BUF) begin
                @(negedge clk);
            end
        end
        repeat (4) @(negedge clk);
        if (blk_count == NUM_BUFFERS * BLOCKS_PER_BUF && exp_blk.size() == 0 &&
            exp_y.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Run ended with %0d blocks and %0d results", blk_count, y_count);
            $display("ERRORS FOUND");
            $fatal(1, "Incomplete run");
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (blk_valid) begin
                if (exp_blk.size() == 0) begin
                    $display("A block came out while none was expected");
                    $display("ERRORS FOUND");
                    $fatal(1, "Unexpected block");
                end else begin
                    check_value("blk_data", blk_data, exp_blk[0]);
                    check_value("slice_done", slice_done,
                                blk_in_buf % TOTAL_BLOCKS == TOTAL_BLOCKS - 1);
                    check_value("slice_last", slice_last, blk_in_buf == BLOCKS_PER_BUF - 1);
                    void'(exp_blk.pop_front());
                    blk_count++;
                    if (blk_in_buf == BLOCKS_PER_BUF - 1) begin
                        // buffer_done must already have been seen once
                        check_value("buffer_done count", buf_done_in_buf, 1);
                        buf_done_in_buf = 0;
                        blk_in_buf      = 0;
                    end else begin
                        blk_in_buf++;
                    end
                end
            end else begin
                check_value("slice_done", slice_done, 0);
                check_value("slice_last", slice_last, 0);
                if (blk_in_buf != 0) begin
                    check_value("blk_valid", blk_valid, 1);
                end
            end
            if (buffer_done) begin
                buf_done_in_buf++;
                check_value("buffer_done count", buf_done_in_buf, 1);
            end
            check_value("y_valid", y_valid, prev_blk_valid);
            if (y_valid) begin
                check_value("y0", $unsigned(y0), exp_y[0][WIDTH-1:0]);
                check_value("y1", $unsigned(y1), exp_y[0][2*WIDTH-1:WIDTH]);
                void'(exp_y.pop_front());
                y_count++;
            end
            prev_blk_valid = blk_valid;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== src.f ====
hw/fixp_pkg.sv
hw/wbuf_pkg.sv
hw/row_assembler.sv
hw/ram_1w2r.sv
hw/r2b_converter_w.sv
hw/weight_block_core.sv
hw/weight_stream_top.sv
bench/weight_stream_sva.sv
bench/tb_weight_stream.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_weight_stream -f src.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
